// File: compile.f
src/axi_addr_pkg.sv
src/axi_lite_cmd_manager.sv
src/axi_address_width_converter.sv
src/axi_chan_reg.sv
src/axi_lite_mem.sv
src/axi_addr_conv_top.sv
dv/tb_clk_gen.sv
dv/tb_axi_addr_conv.sv

// File: Makefile
# Verilator flow for the AXI4-Lite address width converter project
# All variables can be overridden from the command line, e.g. make sim TOP=...

VERILATOR ?= verilator
TOP       ?= tb_axi_addr_conv
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= >>> PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Run output is shown, then searched for the pass line
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// File: dv/tb_axi_addr_conv.sv
// Table-driven testbench for the AXI4-Lite address conversion path with shadow memory model
`timescale 1ns/1ps
`default_nettype none

module tb_axi_addr_conv
  import axi_addr_pkg::*;
();

  localparam int NUM_DIRECTED   = 9;
  localparam int NUM_RANDOM     = 24;
  localparam int NUM_TESTS      = NUM_DIRECTED + NUM_RANDOM;
  localparam int RESET_CYCLES   = 8;
  // Generous per-command budget
  localparam int TIMEOUT_CYCLES = NUM_TESTS * 50 + RESET_CYCLES;

  typedef struct {
    string                 name;
    bit                    write;
    logic [MGR_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]     wdata;
    logic [STRB_W-1:0]     wstrb;
    logic [DATA_W-1:0]     exp_rdata;
    logic [1:0]            exp_resp;
  } test_t;

  logic                  clk;
  logic                  rst_n;
  logic                  cmd_valid;
  logic                  cmd_ready;
  logic                  cmd_write;
  logic [MGR_ADDR_W-1:0] cmd_addr;
  logic [DATA_W-1:0]     cmd_wdata;
  logic [STRB_W-1:0]     cmd_wstrb;
  logic                  rsp_valid;
  logic [DATA_W-1:0]     rsp_rdata;
  logic [1:0]            rsp_resp;

  test_t             tests [NUM_TESTS];
  int                num_built;
  // Expected memory image, indexed by address bits 11 down to 2
  logic [DATA_W-1:0] shadow [MEM_DEPTH];
  bit                written [MEM_DEPTH];
  integer            seed;
  int                errors;
  int                passed;
  int                failed;

  tb_clk_gen clk_gen_i (
    .clk,
    .rst_n
  );

  axi_addr_conv_top dut_i (
    .clk, .rst_n, .cmd_valid, .cmd_ready, .cmd_write, .cmd_addr, .cmd_wdata, .cmd_wstrb,
    .rsp_valid, .rsp_rdata, .rsp_resp
  );

  // New word after a strobed write over the old one
  function automatic logic [DATA_W-1:0] merge_strobed(input logic [DATA_W-1:0] old_word,
                                                      input logic [DATA_W-1:0] new_word,
                                                      input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] result;
    result = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        result[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return result;
  endfunction

  task automatic add_write(input string name, input logic [MGR_ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
    logic [9:0] idx;
    idx = addr[SUB_ADDR_W-1:2];
    tests[num_built].name      = name;
    tests[num_built].write     = 1'b1;
    tests[num_built].addr      = addr;
    tests[num_built].wdata     = data;
    tests[num_built].wstrb     = strb;
    tests[num_built].exp_rdata = '0;
    // Misaligned writes error out and leave the word alone
    if (addr[1:0] == 2'b00) begin
      tests[num_built].exp_resp = RESP_OKAY;
      shadow[idx]  = merge_strobed(shadow[idx], data, strb);
      written[idx] = 1'b1;
    end else begin
      tests[num_built].exp_resp = RESP_SLVERR;
    end
    num_built++;
  endtask

  task automatic add_read(input string name, input logic [MGR_ADDR_W-1:0] addr);
    logic [9:0] idx;
    idx = addr[SUB_ADDR_W-1:2];
    tests[num_built].name  = name;
    tests[num_built].write = 1'b0;
    tests[num_built].addr  = addr;
    tests[num_built].wdata = '0;
    tests[num_built].wstrb = '0;
    if (addr[1:0] == 2'b00) begin
      tests[num_built].exp_rdata = shadow[idx];
      tests[num_built].exp_resp  = RESP_OKAY;
    end else begin
      tests[num_built].exp_rdata = '0;
      tests[num_built].exp_resp  = RESP_SLVERR;
    end
    num_built++;
  endtask

  task automatic build_table();
    logic [31:0]           r_word;
    logic [31:0]           r_upper;
    logic [31:0]           r_data;
    logic [9:0]            word;
    logic [MGR_ADDR_W-1:0] addr;
    num_built = 0;
    add_write("full_word_write", 32'h0000_0100, 32'hDEAD_BEEF, 4'hF);
    add_read("full_word_read", 32'h0000_0100);
    // Only bits above 11 differ, same word underneath
    add_write("alias_write", 32'hABCD_0200, 32'h1234_5678, 4'hF);
    add_read("alias_read", 32'h5555_F200);
    add_write("strobe_write", 32'h7000_0100, 32'hA5A5_A5A5, 4'b0101);
    add_read("strobe_read", 32'h0000_0100);
    add_write("misaligned_write", 32'h0000_0201, 32'hFFFF_FFFF, 4'hF);
    add_read("after_misaligned_read", 32'h0000_0200);
    add_read("misaligned_read", 32'h0000_0102);
    // Random traffic over 16 words, reads only of words already written
    for (int i = 0; i < NUM_RANDOM; i++) begin
      r_word  = $random(seed);
      r_upper = $random(seed);
      r_data  = $random(seed);
      word    = 10'h100 + {6'd0, r_word[3:0]};
      addr    = {r_upper[MGR_ADDR_W-SUB_ADDR_W-1:0], word, 2'b00};
      if (r_word[4] || !written[word]) begin
        add_write($sformatf("rand_write_%0d", i), addr, r_data, 4'hF);
      end else begin
        add_read($sformatf("rand_read_%0d", i), addr);
      end
    end
  endtask

  // Drives one entry from a falling edge and checks the response pulse
  task automatic run_command(input int idx);
    test_t t;
    int    errors_before;
    t = tests[idx];
    errors_before = errors;
    cmd_write = t.write;
    cmd_addr  = t.addr;
    cmd_wdata = t.wdata;
    cmd_wstrb = t.wstrb;
    cmd_valid = 1'b1;
    while (!cmd_ready) begin
      @(negedge clk);
    end
    // Taken on the next rising edge
    @(negedge clk);
    cmd_valid = 1'b0;
    while (!rsp_valid) begin
      @(negedge clk);
    end
    assert (rsp_resp === t.exp_resp) else begin
      $display("[ERROR] %s resp expected %0h actual %0h", t.name, t.exp_resp, rsp_resp);
      errors++;
    end
    if (!t.write) begin
      assert (rsp_rdata === t.exp_rdata) else begin
        $display("[ERROR] %s rdata expected %08h actual %08h", t.name, t.exp_rdata,
                 rsp_rdata);
        errors++;
      end
    end
    if (errors == errors_before) begin
      $display("%s ok", t.name);
      passed++;
    end else begin
      $display("%s failed", t.name);
      failed++;
    end
  endtask

  initial begin
    cmd_valid = 1'b0;
    cmd_write = 1'b0;
    cmd_addr  = '0;
    cmd_wdata = '0;
    cmd_wstrb = '0;
    seed      = 32'h06d0339c;
    errors    = 0;
    passed    = 0;
    failed    = 0;
    build_table();
    @(posedge rst_n);
    @(negedge clk);
    for (int k = 0; k < NUM_TESTS; k++) begin
      run_command(k);
    end
    $display("Tests %0d, passed %0d, failed %0d, check errors %0d", NUM_TESTS, passed,
             failed, errors);
    if (errors == 0 && failed == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog against a stuck handshake
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout, no response after %0d cycles", TIMEOUT_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
// Testbench clock and reset source, 10 ns clock and active-low reset for 8 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD_NS = 5;
  localparam int RESET_CYCLES   = 8;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD_NS clk = ~clk;
  end

  // Release on a falling edge, away from the flops' sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: src/axi_addr_conv_top.sv
// Top level joining command manager, address converter, channel stages and word memory
`timescale 1ns/1ps
`default_nettype none

module axi_addr_conv_top
  import axi_addr_pkg::*;
(
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   cmd_valid,
  output logic                  cmd_ready,
  input  wire                   cmd_write,
  input  wire  [MGR_ADDR_W-1:0] cmd_addr,
  input  wire  [DATA_W-1:0]     cmd_wdata,
  input  wire  [STRB_W-1:0]     cmd_wstrb,
  output logic                  rsp_valid,
  output logic [DATA_W-1:0]     rsp_rdata,
  output logic [1:0]            rsp_resp
);

  // Manager to converter, full address
  logic [MGR_ADDR_W-1:0] m_aw_addr, m_ar_addr;
  logic                  m_aw_valid, m_aw_ready, m_w_valid, m_w_ready;
  logic [DATA_W-1:0]     m_w_data, m_r_data;
  logic [STRB_W-1:0]     m_w_strb;
  logic [1:0]            m_b_resp, m_r_resp;
  logic                  m_b_valid, m_b_ready, m_ar_valid, m_ar_ready;
  logic                  m_r_valid, m_r_ready;

  // Converter to channel stages, truncated address
  logic [SUB_ADDR_W-1:0] s_aw_addr, s_ar_addr;
  logic                  s_aw_valid, s_aw_ready, s_w_valid, s_w_ready;
  logic [DATA_W-1:0]     s_w_data, s_r_data;
  logic [STRB_W-1:0]     s_w_strb;
  logic [1:0]            s_b_resp, s_r_resp;
  logic                  s_b_valid, s_b_ready, s_ar_valid, s_ar_ready;
  logic                  s_r_valid, s_r_ready;

  // Channel stages to memory
  logic [SUB_ADDR_W-1:0] mem_aw_addr, mem_ar_addr;
  logic                  mem_aw_valid, mem_aw_ready, mem_w_valid, mem_w_ready;
  logic [DATA_W-1:0]     mem_w_data, mem_r_data;
  logic [STRB_W-1:0]     mem_w_strb;
  logic [1:0]            mem_b_resp, mem_r_resp;
  logic                  mem_b_valid, mem_b_ready, mem_ar_valid, mem_ar_ready;
  logic                  mem_r_valid, mem_r_ready;

  axi_lite_cmd_manager mgr_i (
    .clk, .rst_n, .cmd_valid, .cmd_ready, .cmd_write, .cmd_addr, .cmd_wdata, .cmd_wstrb,
    .rsp_valid, .rsp_rdata, .rsp_resp,
    .aw_addr(m_aw_addr), .aw_valid(m_aw_valid), .aw_ready(m_aw_ready),
    .w_data(m_w_data), .w_strb(m_w_strb), .w_valid(m_w_valid), .w_ready(m_w_ready),
    .b_resp(m_b_resp), .b_valid(m_b_valid), .b_ready(m_b_ready),
    .ar_addr(m_ar_addr), .ar_valid(m_ar_valid), .ar_ready(m_ar_ready),
    .r_data(m_r_data), .r_resp(m_r_resp), .r_valid(m_r_valid), .r_ready(m_r_ready)
  );

  axi_address_width_converter #(
    .SlvAddrWidth(MGR_ADDR_W),
    .MstAddrWidth(SUB_ADDR_W),
    .AddrOffset  (0)
  ) conv_i (
    .slv_aw_addr(m_aw_addr), .slv_aw_valid(m_aw_valid), .slv_aw_ready(m_aw_ready),
    .slv_w_data(m_w_data), .slv_w_strb(m_w_strb), .slv_w_valid(m_w_valid),
    .slv_w_ready(m_w_ready), .slv_b_resp(m_b_resp), .slv_b_valid(m_b_valid),
    .slv_b_ready(m_b_ready), .slv_ar_addr(m_ar_addr), .slv_ar_valid(m_ar_valid),
    .slv_ar_ready(m_ar_ready), .slv_r_data(m_r_data), .slv_r_resp(m_r_resp),
    .slv_r_valid(m_r_valid), .slv_r_ready(m_r_ready),
    .mst_aw_addr(s_aw_addr), .mst_aw_valid(s_aw_valid), .mst_aw_ready(s_aw_ready),
    .mst_w_data(s_w_data), .mst_w_strb(s_w_strb), .mst_w_valid(s_w_valid),
    .mst_w_ready(s_w_ready), .mst_b_resp(s_b_resp), .mst_b_valid(s_b_valid),
    .mst_b_ready(s_b_ready), .mst_ar_addr(s_ar_addr), .mst_ar_valid(s_ar_valid),
    .mst_ar_ready(s_ar_ready), .mst_r_data(s_r_data), .mst_r_resp(s_r_resp),
    .mst_r_valid(s_r_valid), .mst_r_ready(s_r_ready)
  );

  // Request stages toward the memory
  axi_chan_reg #(.Width(SUB_ADDR_W)) aw_reg_i (
    .clk, .rst_n,
    .in_valid(s_aw_valid), .in_ready(s_aw_ready), .in_data(s_aw_addr),
    .out_valid(mem_aw_valid), .out_ready(mem_aw_ready), .out_data(mem_aw_addr)
  );

  axi_chan_reg #(.Width(DATA_W + STRB_W)) w_reg_i (
    .clk, .rst_n,
    .in_valid(s_w_valid), .in_ready(s_w_ready), .in_data({s_w_data, s_w_strb}),
    .out_valid(mem_w_valid), .out_ready(mem_w_ready), .out_data({mem_w_data, mem_w_strb})
  );

  axi_chan_reg #(.Width(SUB_ADDR_W)) ar_reg_i (
    .clk, .rst_n,
    .in_valid(s_ar_valid), .in_ready(s_ar_ready), .in_data(s_ar_addr),
    .out_valid(mem_ar_valid), .out_ready(mem_ar_ready), .out_data(mem_ar_addr)
  );

  // Response stages back toward the converter
  axi_chan_reg #(.Width(2)) b_reg_i (
    .clk, .rst_n,
    .in_valid(mem_b_valid), .in_ready(mem_b_ready), .in_data(mem_b_resp),
    .out_valid(s_b_valid), .out_ready(s_b_ready), .out_data(s_b_resp)
  );

  axi_chan_reg #(.Width(DATA_W + 2)) r_reg_i (
    .clk, .rst_n,
    .in_valid(mem_r_valid), .in_ready(mem_r_ready), .in_data({mem_r_data, mem_r_resp}),
    .out_valid(s_r_valid), .out_ready(s_r_ready), .out_data({s_r_data, s_r_resp})
  );

  axi_lite_mem mem_i (
    .clk, .rst_n,
    .aw_addr(mem_aw_addr), .aw_valid(mem_aw_valid), .aw_ready(mem_aw_ready),
    .w_data(mem_w_data), .w_strb(mem_w_strb), .w_valid(mem_w_valid), .w_ready(mem_w_ready),
    .b_resp(mem_b_resp), .b_valid(mem_b_valid), .b_ready(mem_b_ready),
    .ar_addr(mem_ar_addr), .ar_valid(mem_ar_valid), .ar_ready(mem_ar_ready),
    .r_data(mem_r_data), .r_resp(mem_r_resp), .r_valid(mem_r_valid), .r_ready(mem_r_ready)
  );

endmodule

`default_nettype wire

// File: src/axi_lite_mem.sv
// AXI4-Lite word memory with byte strobes and error response on misaligned access
`timescale 1ns/1ps
`default_nettype none

module axi_lite_mem
  import axi_addr_pkg::*;
(
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire  [SUB_ADDR_W-1:0] aw_addr,
  input  wire                   aw_valid,
  output logic                  aw_ready,
  input  wire  [DATA_W-1:0]     w_data,
  input  wire  [STRB_W-1:0]     w_strb,
  input  wire                   w_valid,
  output logic                  w_ready,
  output logic [1:0]            b_resp,
  output logic                  b_valid,
  input  wire                   b_ready,
  input  wire  [SUB_ADDR_W-1:0] ar_addr,
  input  wire                   ar_valid,
  output logic                  ar_ready,
  output logic [DATA_W-1:0]     r_data,
  output logic [1:0]            r_resp,
  output logic                  r_valid,
  input  wire                   r_ready
);

  logic [DATA_W-1:0] mem_q [MEM_DEPTH];
  sub_addr_u         aw_dec;
  sub_addr_u         ar_dec;
  logic              wr_fire;
  logic              rd_fire;
  logic              wr_aligned;
  logic              rd_aligned;
  logic              b_valid_q;
  logic [1:0]        b_resp_q;
  logic              r_valid_q;
  logic [1:0]        r_resp_q;
  logic [DATA_W-1:0] r_data_q;

  // Byte address in, word index and offset out
  assign aw_dec.raw = aw_addr;
  assign ar_dec.raw = ar_addr;
  assign wr_aligned = (aw_dec.fields.byte_offset == 2'b00);
  assign rd_aligned = (ar_dec.fields.byte_offset == 2'b00);

  // AW and W are taken together, one write response in flight
  assign wr_fire  = aw_valid && w_valid && !b_valid_q;
  assign aw_ready = wr_fire;
  assign w_ready  = wr_fire;

  // One read response in flight
  assign ar_ready = !r_valid_q;
  assign rd_fire  = ar_valid && ar_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_fire) begin
        b_valid_q <= 1'b1;
      end else if (b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_fire) begin
        r_valid_q <= 1'b1;
      end else if (r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  // Strobed byte update, misaligned writes leave the array alone
  always_ff @(posedge clk) begin
    if (wr_fire && wr_aligned) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (w_strb[i]) begin
          mem_q[aw_dec.fields.word_index][i*8 +: 8] <= w_data[i*8 +: 8];
        end
      end
    end
  end

  // Response payloads
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      b_resp_q <= wr_aligned ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_fire) begin
      r_resp_q <= rd_aligned ? RESP_OKAY : RESP_SLVERR;
      // Errored reads return zero
      r_data_q <= rd_aligned ? mem_q[ar_dec.fields.word_index] : '0;
    end
  end

  assign b_valid = b_valid_q;
  assign b_resp  = b_resp_q;
  assign r_valid = r_valid_q;
  assign r_resp  = r_resp_q;
  assign r_data  = r_data_q;

  // A write address waiting for its data stays offered and unchanged
  a_b_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (aw_valid && !aw_ready) |=> (aw_valid && $stable(aw_addr))
  );

endmodule

`default_nettype wire

// File: src/axi_chan_reg.sv
// One-entry ready/valid register stage for a single AXI channel
`timescale 1ns/1ps
`default_nettype none

module axi_chan_reg #(
  parameter int unsigned Width = 8
) (
  input  wire              clk,
  input  wire              rst_n,
  input  wire              in_valid,
  output logic             in_ready,
  input  wire  [Width-1:0] in_data,
  output logic             out_valid,
  input  wire              out_ready,
  output logic [Width-1:0] out_data
);

  logic             full_q;
  logic [Width-1:0] data_q;

  // Take a new item when empty or when the held one leaves this cycle
  assign in_ready = !full_q || out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (in_ready) begin
      full_q <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      data_q <= in_data;
    end
  end

  assign out_valid = full_q;
  assign out_data  = data_q;

  // A stalled source keeps its item offered and unchanged
  a_stable_on_stall: assert property (
    @(posedge clk) disable iff (!rst_n)
    (in_valid && !in_ready) |=> (in_valid && $stable(in_data))
  );

endmodule

`default_nettype wire

// File: src/axi_address_width_converter.sv
// AXI4-Lite address width converter, truncates or offset-extends AW/AR and feeds all else through
`timescale 1ns/1ps
`default_nettype none

module axi_address_width_converter
  import axi_addr_pkg::*;
#(
  parameter int unsigned     SlvAddrWidth = 32,
  parameter int unsigned     MstAddrWidth = 12,
  // Upper address bits used when widening
  parameter longint unsigned AddrOffset   = 0
) (
  // Slave side, faces the manager
  input  wire  [SlvAddrWidth-1:0] slv_aw_addr,
  input  wire                     slv_aw_valid,
  output logic                    slv_aw_ready,
  input  wire  [DATA_W-1:0]       slv_w_data,
  input  wire  [STRB_W-1:0]       slv_w_strb,
  input  wire                     slv_w_valid,
  output logic                    slv_w_ready,
  output logic [1:0]              slv_b_resp,
  output logic                    slv_b_valid,
  input  wire                     slv_b_ready,
  input  wire  [SlvAddrWidth-1:0] slv_ar_addr,
  input  wire                     slv_ar_valid,
  output logic                    slv_ar_ready,
  output logic [DATA_W-1:0]       slv_r_data,
  output logic [1:0]              slv_r_resp,
  output logic                    slv_r_valid,
  input  wire                     slv_r_ready,
  // Master side, faces the subordinate
  output logic [MstAddrWidth-1:0] mst_aw_addr,
  output logic                    mst_aw_valid,
  input  wire                     mst_aw_ready,
  output logic [DATA_W-1:0]       mst_w_data,
  output logic [STRB_W-1:0]       mst_w_strb,
  output logic                    mst_w_valid,
  input  wire                     mst_w_ready,
  input  wire  [1:0]              mst_b_resp,
  input  wire                     mst_b_valid,
  output logic                    mst_b_ready,
  output logic [MstAddrWidth-1:0] mst_ar_addr,
  output logic                    mst_ar_valid,
  input  wire                     mst_ar_ready,
  input  wire  [DATA_W-1:0]       mst_r_data,
  input  wire  [1:0]              mst_r_resp,
  input  wire                     mst_r_valid,
  output logic                    mst_r_ready
);

  if (SlvAddrWidth > MstAddrWidth) begin : gen_truncate
    // Upper bits are dropped, so windows alias downstream
    assign mst_aw_addr = slv_aw_addr[MstAddrWidth-1:0];
    assign mst_ar_addr = slv_ar_addr[MstAddrWidth-1:0];
  end else if (SlvAddrWidth < MstAddrWidth) begin : gen_extend
    assign mst_aw_addr = {AddrOffset[MstAddrWidth-SlvAddrWidth-1:0], slv_aw_addr};
    assign mst_ar_addr = {AddrOffset[MstAddrWidth-SlvAddrWidth-1:0], slv_ar_addr};
  end else begin : gen_feedthrough
    assign mst_aw_addr = slv_aw_addr;
    assign mst_ar_addr = slv_ar_addr;
  end

  // Request handshakes and payloads
  assign mst_aw_valid = slv_aw_valid;
  assign slv_aw_ready = mst_aw_ready;
  assign mst_w_data   = slv_w_data;
  assign mst_w_strb   = slv_w_strb;
  assign mst_w_valid  = slv_w_valid;
  assign slv_w_ready  = mst_w_ready;
  assign mst_ar_valid = slv_ar_valid;
  assign slv_ar_ready = mst_ar_ready;

  // Responses go back untouched
  assign slv_b_resp   = mst_b_resp;
  assign slv_b_valid  = mst_b_valid;
  assign mst_b_ready  = slv_b_ready;
  assign slv_r_data   = mst_r_data;
  assign slv_r_resp   = mst_r_resp;
  assign slv_r_valid  = mst_r_valid;
  assign mst_r_ready  = slv_r_ready;

endmodule

`default_nettype wire

// File: src/axi_lite_cmd_manager.sv
// Command manager that turns one command at a time into AXI4-Lite traffic and returns the response
`timescale 1ns/1ps
`default_nettype none

module axi_lite_cmd_manager
  import axi_addr_pkg::*;
(
  input  wire                  clk,
  input  wire                  rst_n,
  // Command port
  input  wire                  cmd_valid,
  output logic                 cmd_ready,
  input  wire                  cmd_write,
  input  wire [MGR_ADDR_W-1:0] cmd_addr,
  input  wire [DATA_W-1:0]     cmd_wdata,
  input  wire [STRB_W-1:0]     cmd_wstrb,
  // Response port, one-cycle pulse
  output logic                 rsp_valid,
  output logic [DATA_W-1:0]    rsp_rdata,
  output logic [1:0]           rsp_resp,
  // AXI4-Lite manager side
  output logic [MGR_ADDR_W-1:0] aw_addr,
  output logic                 aw_valid,
  input  wire                  aw_ready,
  output logic [DATA_W-1:0]    w_data,
  output logic [STRB_W-1:0]    w_strb,
  output logic                 w_valid,
  input  wire                  w_ready,
  input  wire  [1:0]           b_resp,
  input  wire                  b_valid,
  output logic                 b_ready,
  output logic [MGR_ADDR_W-1:0] ar_addr,
  output logic                 ar_valid,
  input  wire                  ar_ready,
  input  wire  [DATA_W-1:0]    r_data,
  input  wire  [1:0]           r_resp,
  input  wire                  r_valid,
  output logic                 r_ready
);

  logic [MGR_ST_W-1:0]   state_q;
  // Holds cmd_ready low for the first cycle out of reset
  logic                  init_q;
  // AW and W complete independently
  logic                  aw_pend_q;
  logic                  w_pend_q;
  logic [MGR_ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0]     wdata_q;
  logic [STRB_W-1:0]     wstrb_q;
  logic                  rsp_valid_q;
  logic [DATA_W-1:0]     rsp_rdata_q;
  logic [1:0]            rsp_resp_q;
  logic                  cmd_fire;
  logic                  aw_left;
  logic                  w_left;

  assign cmd_ready = init_q && (state_q == MGR_IDLE);
  assign cmd_fire  = cmd_valid && cmd_ready;

  // Channel still owed after this cycle
  assign aw_left = aw_pend_q && !aw_ready;
  assign w_left  = w_pend_q && !w_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= MGR_IDLE;
      init_q      <= 1'b0;
      aw_pend_q   <= 1'b0;
      w_pend_q    <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      init_q      <= 1'b1;
      rsp_valid_q <= 1'b0;
      case (state_q)
        MGR_IDLE: begin
          if (cmd_fire) begin
            // Raise the request channels on the next cycle
            state_q   <= cmd_write ? MGR_WR_AD : MGR_RD_ADDR;
            aw_pend_q <= cmd_write;
            w_pend_q  <= cmd_write;
          end
        end
        MGR_WR_AD: begin
          aw_pend_q <= aw_left;
          w_pend_q  <= w_left;
          if (!aw_left && !w_left) begin
            state_q <= MGR_WR_RESP;
          end
        end
        MGR_WR_RESP: begin
          if (b_valid) begin
            state_q     <= MGR_IDLE;
            rsp_valid_q <= 1'b1;
          end
        end
        MGR_RD_ADDR: begin
          if (ar_ready) begin
            state_q <= MGR_RD_DATA;
          end
        end
        MGR_RD_DATA: begin
          if (r_valid) begin
            state_q     <= MGR_IDLE;
            rsp_valid_q <= 1'b1;
          end
        end
        default: state_q <= MGR_IDLE;
      endcase
    end
  end

  // Command payload, held for the whole transaction
  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      addr_q  <= cmd_addr;
      wdata_q <= cmd_wdata;
      wstrb_q <= cmd_wstrb;
    end
  end

  // Capture whichever response ends the transaction
  always_ff @(posedge clk) begin
    if (b_valid && b_ready) begin
      rsp_rdata_q <= '0;
      rsp_resp_q  <= b_resp;
    end else if (r_valid && r_ready) begin
      rsp_rdata_q <= r_data;
      rsp_resp_q  <= r_resp;
    end
  end

  assign aw_addr  = addr_q;
  assign aw_valid = aw_pend_q;
  assign w_data   = wdata_q;
  assign w_strb   = wstrb_q;
  assign w_valid  = w_pend_q;
  assign b_ready  = (state_q == MGR_WR_RESP);
  assign ar_addr  = addr_q;
  assign ar_valid = (state_q == MGR_RD_ADDR);
  assign r_ready  = (state_q == MGR_RD_DATA);

  assign rsp_valid = rsp_valid_q;
  assign rsp_rdata = rsp_rdata_q;
  assign rsp_resp  = rsp_resp_q;

  // A command is only taken once the path is idle, no response left in flight
  a_cmd_only_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    cmd_fire |-> (!b_valid && !r_valid)
  );

endmodule

`default_nettype wire

// File: src/axi_addr_pkg.sv
// Shared widths, response codes, FSM encodings and subordinate address decode for the AXI path
`default_nettype none

package axi_addr_pkg;

  // Manager side carries a full 32-bit address
  localparam int unsigned MGR_ADDR_W = 32;
  // Subordinate only decodes one 4 KiB window
  localparam int unsigned SUB_ADDR_W = 12;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned STRB_W     = DATA_W / 8;
  localparam int unsigned MEM_DEPTH  = 1024;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Command manager FSM encodings
  localparam int unsigned MGR_ST_W    = 3;
  localparam logic [2:0]  MGR_IDLE    = 3'd0;
  localparam logic [2:0]  MGR_WR_AD   = 3'd1;
  localparam logic [2:0]  MGR_WR_RESP = 3'd2;
  localparam logic [2:0]  MGR_RD_ADDR = 3'd3;
  localparam logic [2:0]  MGR_RD_DATA = 3'd4;

  // Word view of a subordinate byte address
  typedef struct packed {
    logic [9:0] word_index;
    logic [1:0] byte_offset;
  } sub_addr_fields_s;

  // Same 12 bits seen either as a byte address or as word plus offset
  typedef union packed {
    logic [SUB_ADDR_W-1:0] raw;
    sub_addr_fields_s      fields;
  } sub_addr_u;

endpackage

`default_nettype wire
